//--- all.f
source/dcache_pkg.sv
source/dcache_lookup.sv
source/dcache_control.sv
source/dcache_frames.sv
source/dcache.sv
tb/tb_dcache_assertions.sv
tb/tb_dcache.sv

//--- run.sh
#!/bin/sh
# compile and run the data cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_dcache \
    -f all.f \
    -Mdir obj_dir -o sim_dcache

./obj_dir/sim_dcache +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log; then
    echo "run.sh: failures found in sim.log"
    exit 1
fi
echo "run.sh: no failures in sim.log"

//--- source/dcache.sv
`default_nettype none

module dcache (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              halt,
    input  logic              dmemREN,
    input  logic              dmemWEN,
    input  logic              datomic,
    input  dcache_pkg::word_t dmemaddr,
    input  dcache_pkg::word_t dmemstore,
    output logic              dhit,
    output dcache_pkg::word_t dmemload,
    output logic              flushed,
    output logic              dREN,
    output logic              dWEN,
    output dcache_pkg::word_t daddr,
    output dcache_pkg::word_t dstore,
    input  dcache_pkg::word_t dload,
    input  logic              dwait
);

    dcache_pkg::daddr_u                      req;
    logic                                    hit, hit_way, sc_fail;
    logic                                    victim_way, victim_dirty;
    logic                                    req_done;
    dcache_pkg::tag_t [dcache_pkg::ways-1:0] way_tag;
    logic [dcache_pkg::ways-1:0]             way_valid, way_dirty;
    logic                                    lru;
    dcache_pkg::tag_t                        rd_tag;
    dcache_pkg::word_t                       rd_data;
    logic                                    rd_dirty;
    logic                                    fill_word, fill_sel, fill_done;
    logic                                    store_hit, touch, clean;
    dcache_pkg::idx_t                        rd_idx;
    logic                                    rd_way, rd_word;

    assign req = dcache_pkg::daddr_u'(dmemaddr);

    dcache_lookup u_lookup (
        .CLK          (CLK),
        .nRST         (nRST),
        .dmemREN      (dmemREN),
        .dmemWEN      (dmemWEN),
        .datomic      (datomic),
        .dmemaddr     (dmemaddr),
        .req_done     (req_done),
        .way_tag      (way_tag),
        .way_valid    (way_valid),
        .way_dirty    (way_dirty),
        .lru          (lru),
        .hit          (hit),
        .hit_way      (hit_way),
        .sc_fail      (sc_fail),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty)
    );

    dcache_control u_control (
        .CLK          (CLK),
        .nRST         (nRST),
        .halt         (halt),
        .dmemREN      (dmemREN),
        .dmemWEN      (dmemWEN),
        .datomic      (datomic),
        .dmemaddr     (dmemaddr),
        .hit          (hit),
        .hit_way      (hit_way),
        .sc_fail      (sc_fail),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .rd_tag       (rd_tag),
        .rd_data      (rd_data),
        .rd_dirty     (rd_dirty),
        .dwait        (dwait),
        .dhit         (dhit),
        .dmemload     (dmemload),
        .flushed      (flushed),
        .req_done     (req_done),
        .dREN         (dREN),
        .dWEN         (dWEN),
        .daddr        (daddr),
        .dstore       (dstore),
        .fill_word    (fill_word),
        .fill_sel     (fill_sel),
        .fill_done    (fill_done),
        .store_hit    (store_hit),
        .touch        (touch),
        .clean        (clean),
        .rd_idx       (rd_idx),
        .rd_way       (rd_way),
        .rd_word      (rd_word)
    );

    dcache_frames u_frames (
        .CLK          (CLK),
        .nRST         (nRST),
        .idx          (req.fields.idx),
        .blkoff       (req.fields.blkoff),
        .dmemstore    (dmemstore),
        .dload        (dload),
        .fill_tag     (req.fields.tag),
        .fill_word    (fill_word),
        .fill_sel     (fill_sel),
        .fill_done    (fill_done),
        .store_hit    (store_hit),
        .touch        (touch),
        .clean        (clean),
        .rd_idx       (rd_idx),
        .rd_way       (rd_way),
        .rd_word      (rd_word),
        .way_tag      (way_tag),
        .way_valid    (way_valid),
        .way_dirty    (way_dirty),
        .lru          (lru),
        .rd_tag       (rd_tag),
        .rd_data      (rd_data),
        .rd_dirty     (rd_dirty)
    );

endmodule

`default_nettype wire

//--- source/dcache_control.sv
`default_nettype none

module dcache_control (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    halt,
    input  logic                    dmemREN,
    input  logic                    dmemWEN,
    input  logic                    datomic,
    input  dcache_pkg::word_t       dmemaddr,
    input  logic                    hit,
    input  logic                    hit_way,
    input  logic                    sc_fail,
    input  logic                    victim_way,
    input  logic                    victim_dirty,
    input  dcache_pkg::tag_t        rd_tag,
    input  dcache_pkg::word_t       rd_data,
    input  logic                    rd_dirty,
    input  logic                    dwait,
    output logic                    dhit,
    output dcache_pkg::word_t       dmemload,
    output logic                    flushed,
    output logic                    req_done,
    output logic                    dREN,
    output logic                    dWEN,
    output dcache_pkg::word_t       daddr,
    output dcache_pkg::word_t       dstore,
    output logic                    fill_word,
    output logic                    fill_sel,
    output logic                    fill_done,
    output logic                    store_hit,
    output logic                    touch,
    output logic                    clean,
    output dcache_pkg::idx_t        rd_idx,
    output logic                    rd_way,
    output logic                    rd_word
);

    dcache_pkg::state_t                state, nxt_state;
    dcache_pkg::daddr_u                req;
    dcache_pkg::daddr_u                mem;
    logic                              halt_q;
    logic [dcache_pkg::frame_w-1:0]    cnt;
    logic                              frame_done;

    assign req      = dcache_pkg::daddr_u'(dmemaddr);
    assign daddr    = mem.raw;
    assign req_done = dhit;
    assign flushed  = (state == dcache_pkg::flushed);

    always_comb begin
        nxt_state  = state;
        dhit       = 1'b0;
        dmemload   = '0;
        dREN       = 1'b0;
        dWEN       = 1'b0;
        dstore     = '0;
        fill_word  = 1'b0;
        fill_sel   = 1'b0;
        fill_done  = 1'b0;
        store_hit  = 1'b0;
        touch      = 1'b0;
        clean      = 1'b0;
        frame_done = 1'b0;
        rd_idx     = req.fields.idx;
        rd_way     = victim_way;
        rd_word    = req.fields.blkoff;
        mem        = '0;
        mem.fields.tag = req.fields.tag;
        mem.fields.idx = req.fields.idx;

        case (state)
            dcache_pkg::idle: begin
                rd_way = hit_way;
                if (halt_q) begin
                    nxt_state = dcache_pkg::flush0;
                end else if (dmemREN || dmemWEN) begin
                    if (dmemWEN && datomic && sc_fail) begin
                        dhit = 1'b1;   // sc fails, returns 0
                    end else if (hit) begin
                        dhit  = 1'b1;
                        touch = 1'b1;
                        if (dmemWEN) begin
                            store_hit = 1'b1;
                            dmemload  = dcache_pkg::word_t'(1);
                        end else begin
                            dmemload = rd_data;
                        end
                    end else begin
                        rd_way    = victim_way;
                        nxt_state = victim_dirty ? dcache_pkg::wb0 : dcache_pkg::fill0;
                    end
                end
            end

            dcache_pkg::wb0, dcache_pkg::wb1: begin
                rd_word = (state == dcache_pkg::wb1);
                dWEN    = 1'b1;
                dstore  = rd_data;
                mem.fields.tag    = rd_tag;   // victim's own address
                mem.fields.blkoff = rd_word;
                if (!dwait) begin
                    if (state == dcache_pkg::wb0) begin
                        nxt_state = dcache_pkg::wb1;
                    end else begin
                        clean     = 1'b1;
                        nxt_state = dcache_pkg::fill0;
                    end
                end
            end

            dcache_pkg::fill0, dcache_pkg::fill1: begin
                fill_sel = (state == dcache_pkg::fill1);
                dREN     = 1'b1;
                mem.fields.blkoff = fill_sel;
                if (!dwait) begin
                    fill_word = 1'b1;
                    if (state == dcache_pkg::fill0) begin
                        nxt_state = dcache_pkg::fill1;
                    end else begin
                        fill_done = 1'b1;
                        nxt_state = dcache_pkg::idle;   // request is looked up again
                    end
                end
            end

            dcache_pkg::flush0, dcache_pkg::flush1: begin
                rd_idx  = cnt[3:1];
                rd_way  = cnt[0];
                rd_word = (state == dcache_pkg::flush1);
                mem.fields.tag    = rd_tag;
                mem.fields.idx    = cnt[3:1];
                mem.fields.blkoff = rd_word;
                if (!rd_dirty) begin
                    frame_done = 1'b1;   // clean frame, skip
                end else begin
                    dWEN   = 1'b1;
                    dstore = rd_data;
                    if (!dwait) begin
                        if (state == dcache_pkg::flush0) begin
                            nxt_state = dcache_pkg::flush1;
                        end else begin
                            clean      = 1'b1;
                            frame_done = 1'b1;
                            nxt_state  = dcache_pkg::flush0;
                        end
                    end
                end
                if (frame_done && (cnt == '1)) begin
                    nxt_state = dcache_pkg::flushed;
                end
            end

            default: begin
                // flushed holds until reset
            end
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state  <= dcache_pkg::idle;
            halt_q <= 1'b0;
            cnt    <= '0;
        end else begin
            state  <= nxt_state;
            halt_q <= halt_q | halt;
            if (frame_done) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/dcache_frames.sv
`default_nettype none

module dcache_frames (
    input  logic                                     CLK,
    input  logic                                     nRST,
    input  dcache_pkg::idx_t                         idx,
    input  logic                                     blkoff,
    input  dcache_pkg::word_t                        dmemstore,
    input  dcache_pkg::word_t                        dload,
    input  dcache_pkg::tag_t                         fill_tag,
    input  logic                                     fill_word,
    input  logic                                     fill_sel,
    input  logic                                     fill_done,
    input  logic                                     store_hit,
    input  logic                                     touch,
    input  logic                                     clean,
    input  dcache_pkg::idx_t                         rd_idx,
    input  logic                                     rd_way,
    input  logic                                     rd_word,
    output dcache_pkg::tag_t [dcache_pkg::ways-1:0]  way_tag,
    output logic [dcache_pkg::ways-1:0]              way_valid,
    output logic [dcache_pkg::ways-1:0]              way_dirty,
    output logic                                     lru,
    output dcache_pkg::tag_t                         rd_tag,
    output dcache_pkg::word_t                        rd_data,
    output logic                                     rd_dirty
);

    dcache_pkg::tag_t  tag_q   [dcache_pkg::ways][dcache_pkg::sets];
    logic              valid_q [dcache_pkg::ways][dcache_pkg::sets];
    logic              dirty_q [dcache_pkg::ways][dcache_pkg::sets];
    dcache_pkg::word_t data_q  [dcache_pkg::ways][dcache_pkg::sets][2];
    logic [dcache_pkg::sets-1:0] lru_q;

    // lookup view at the requested set
    always_comb begin
        for (int w = 0; w < dcache_pkg::ways; w++) begin
            way_tag[w]   = tag_q[w][idx];
            way_valid[w] = valid_q[w][idx];
            way_dirty[w] = dirty_q[w][idx];
        end
    end

    assign lru = lru_q[idx];

    // selected frame, feeds loads and writebacks
    assign rd_tag   = tag_q[rd_way][rd_idx];
    assign rd_data  = data_q[rd_way][rd_idx][rd_word];
    assign rd_dirty = dirty_q[rd_way][rd_idx];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            lru_q <= '0;
            for (int w = 0; w < dcache_pkg::ways; w++) begin
                for (int s = 0; s < dcache_pkg::sets; s++) begin
                    tag_q[w][s]     <= '0;
                    valid_q[w][s]   <= 1'b0;
                    dirty_q[w][s]   <= 1'b0;
                    data_q[w][s][0] <= '0;
                    data_q[w][s][1] <= '0;
                end
            end
        end else begin
            if (fill_word) begin
                data_q[rd_way][rd_idx][fill_sel] <= dload;
                valid_q[rd_way][rd_idx]          <= 1'b0;   // half filled
            end
            if (fill_done) begin
                tag_q[rd_way][rd_idx]   <= fill_tag;
                valid_q[rd_way][rd_idx] <= 1'b1;
                dirty_q[rd_way][rd_idx] <= 1'b0;
            end
            if (store_hit) begin
                data_q[rd_way][rd_idx][blkoff] <= dmemstore;
                dirty_q[rd_way][rd_idx]        <= 1'b1;
            end
            if (clean) begin
                dirty_q[rd_way][rd_idx] <= 1'b0;
                valid_q[rd_way][rd_idx] <= 1'b0;
            end
            if (touch) begin
                lru_q[idx] <= ~rd_way;   // other way goes next
            end
        end
    end

endmodule

`default_nettype wire

//--- source/dcache_lookup.sv
`default_nettype none

module dcache_lookup (
    input  logic                                     CLK,
    input  logic                                     nRST,
    input  logic                                     dmemREN,
    input  logic                                     dmemWEN,
    input  logic                                     datomic,
    input  dcache_pkg::word_t                        dmemaddr,
    input  logic                                     req_done,
    input  dcache_pkg::tag_t [dcache_pkg::ways-1:0]  way_tag,
    input  logic [dcache_pkg::ways-1:0]              way_valid,
    input  logic [dcache_pkg::ways-1:0]              way_dirty,
    input  logic                                     lru,
    output logic                                     hit,
    output logic                                     hit_way,
    output logic                                     sc_fail,
    output logic                                     victim_way,
    output logic                                     victim_dirty
);

    dcache_pkg::daddr_u          req;
    logic [dcache_pkg::ways-1:0] match;
    dcache_pkg::word_t           link_q;
    logic                        link_valid;

    assign req = dcache_pkg::daddr_u'(dmemaddr);

    always_comb begin
        for (int w = 0; w < dcache_pkg::ways; w++) begin
            match[w] = way_valid[w] && (way_tag[w] == req.fields.tag);
        end
    end

    assign hit     = |match;
    assign hit_way = ~match[0];   // way 0 wins if both match

    // lru bit names the way to replace next
    assign victim_way   = lru;
    assign victim_dirty = way_dirty[lru];

    // store conditional only passes against a live link to the same word
    assign sc_fail = !link_valid || (req.raw != link_q);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            link_q     <= '0;
            link_valid <= 1'b0;
        end else if (req_done) begin
            if (dmemREN && datomic) begin   // load linked
                link_q     <= req.raw;
                link_valid <= 1'b1;
            end else if (dmemWEN && (req.raw == link_q)) begin
                link_valid <= 1'b0;         // any store to the linked word breaks it
            end
        end
    end

endmodule

`default_nettype wire

//--- source/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    localparam int word_w  = 32;
    localparam int tag_w   = 26;
    localparam int idx_w   = 3;
    localparam int sets    = 8;
    localparam int ways    = 2;
    localparam int frame_w = 4;   // 16 frames walked on flush

    typedef logic [word_w-1:0] word_t;
    typedef logic [tag_w-1:0]  tag_t;
    typedef logic [idx_w-1:0]  idx_t;

    // data address, as one word or split for the cache
    typedef union packed {
        word_t raw;
        struct packed {
            tag_t       tag;
            idx_t       idx;
            logic       blkoff;   // word within block
            logic [1:0] byteoff;
        } fields;
    } daddr_u;

    typedef enum logic [2:0] {
        idle,
        fill0,
        fill1,
        wb0,
        wb1,
        flush0,
        flush1,
        flushed
    } state_t;

endpackage

`default_nettype wire

//--- tb/tb_dcache.sv
`default_nettype none

module tb_dcache;

    localparam int          period     = 4;
    localparam int          n_rand     = 300;
    localparam int          n_fixed    = 20;
    localparam int          max_wait   = 3;     // longest run of dwait high
    localparam int          mem_words  = 64;    // 4 tags over all 8 sets
    localparam int          req_cycles = 4 * (max_wait + 1) + 4;
    localparam int          flush_cycles = 16 * 2 * (max_wait + 1) + 8;
    localparam int          watchdog_time = (n_rand + n_fixed + 64) * req_cycles * period;
    localparam logic [31:0] seed_init  = 32'hf9e5;

    logic              CLK;
    logic              nRST;
    logic              halt, dmemREN, dmemWEN, datomic;
    dcache_pkg::word_t dmemaddr, dmemstore, dload;
    logic              dwait;
    logic              dhit, flushed, dREN, dWEN;
    dcache_pkg::word_t dmemload, daddr, dstore;

    integer            seed, wait_seed;
    dcache_pkg::word_t resp_mem  [mem_words];
    dcache_pkg::word_t model_mem [mem_words];
    logic              link_valid;
    dcache_pkg::word_t link_addr;
    int                wait_run, rd_ops, errors, n_pass, n_fail;
    dcache_pkg::word_t wr_log [$];

    dcache dut (
        .CLK       (CLK),
        .nRST      (nRST),
        .halt      (halt),
        .dmemREN   (dmemREN),
        .dmemWEN   (dmemWEN),
        .datomic   (datomic),
        .dmemaddr  (dmemaddr),
        .dmemstore (dmemstore),
        .dhit      (dhit),
        .dmemload  (dmemload),
        .flushed   (flushed),
        .dREN      (dREN),
        .dWEN      (dWEN),
        .daddr     (daddr),
        .dstore    (dstore),
        .dload     (dload),
        .dwait     (dwait)
    );

    always #(period / 2) CLK = ~CLK;

    function automatic dcache_pkg::word_t initial_word(input int i);
        dcache_pkg::word_t a;
        a = dcache_pkg::word_t'(i) << 2;
        return {a[15:0], ~a[15:0]};
    endfunction

    function automatic int total_errs();
        return errors + dut.u_assertions.fails;
    endfunction

    // memory responder completing a word on each edge with dwait low
    always @(posedge CLK) begin
        if (nRST && (dREN || dWEN) && !dwait) begin
            if (daddr[31:8] != '0) begin
                $display("memory access outside the test range at %h", daddr);
                errors++;
            end else if (dWEN) begin
                if (dstore != model_mem[daddr[7:2]]) begin
                    $display("FAILED dstore at %h: got %h expected %h",
                             daddr, dstore, model_mem[daddr[7:2]]);
                    errors++;
                end
                resp_mem[daddr[7:2]] = dstore;
                wr_log.push_back(daddr);
            end else begin
                rd_ops++;
            end
        end
        #1;
        if (wait_run < max_wait && ($random(wait_seed) & 1) != 0) begin
            dwait = 1'b1;
            wait_run++;
        end else begin
            dwait    = 1'b0;
            wait_run = 0;
        end
        dload = resp_mem[daddr[7:2]];
    end

    // one request held until dhit
    task automatic request(input logic ren, input logic wen, input logic atomic,
                           input dcache_pkg::word_t addr, input dcache_pkg::word_t data,
                           output dcache_pkg::word_t load);
        int   cycles;
        logic got;
        cycles    = 0;
        got       = 1'b0;
        load      = '0;
        dmemREN   = ren;
        dmemWEN   = wen;
        datomic   = atomic;
        dmemaddr  = addr;
        dmemstore = data;
        while (!got && cycles < req_cycles) begin
            @(negedge CLK);
            if (dhit) begin
                got  = 1'b1;
                load = dmemload;
            end
            @(posedge CLK);
            #1;
            cycles++;
        end
        dmemREN = 1'b0;
        dmemWEN = 1'b0;
        datomic = 1'b0;
        if (!got) begin
            $display("no dhit within %0d cycles for address %h", req_cycles, addr);
            errors++;
        end
    endtask

    // kind 0 read, 1 write, 2 load linked, 3 store conditional
    task automatic access(input int kind, input dcache_pkg::word_t addr,
                          input dcache_pkg::word_t data);
        dcache_pkg::word_t load;
        dcache_pkg::word_t expect_w;
        int                w;
        logic              sc_ok;
        logic              check;
        w        = int'(addr[7:2]);
        sc_ok    = link_valid && (link_addr == addr);
        check    = 1'b1;
        expect_w = model_mem[w];
        request(kind == 0 || kind == 2, kind == 1 || kind == 3, kind >= 2, addr, data, load);
        if (kind == 2) begin
            link_valid = 1'b1;
            link_addr  = addr;
        end else if (kind == 1 || kind == 3) begin
            if (kind == 1 || sc_ok) begin
                model_mem[w] = data;
            end
            check    = (kind == 3);
            expect_w = sc_ok ? 32'd1 : 32'd0;
            if (addr == link_addr) begin
                link_valid = 1'b0;   // store to the linked word
            end
        end
        if (check && load != expect_w) begin
            $display("FAILED dmemload at %h: got %h expected %h", addr, load, expect_w);
            errors++;
        end
    endtask

    task automatic report(input string name, input int start);
        if (total_errs() == start) begin
            $display("test %s: ok", name);
            n_pass++;
        end else begin
            $display("test %s: %0d errors", name, total_errs() - start);
            n_fail++;
        end
    endtask

    initial begin
        #(watchdog_time);
        $display("watchdog expired at %0t, the DUT stopped answering", $time);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        dcache_pkg::word_t a;
        dcache_pkg::word_t d;
        int                kind;
        int                start;
        int                base;
        int                cycles;
        CLK        = 1'b0;
        nRST       = 1'b0;
        halt       = 1'b0;
        dmemREN    = 1'b0;
        dmemWEN    = 1'b0;
        datomic    = 1'b0;
        dmemaddr   = '0;
        dmemstore  = '0;
        dload      = '0;
        dwait      = 1'b0;
        seed       = seed_init;
        wait_seed  = seed_init;
        link_valid = 1'b0;
        link_addr  = '0;
        wait_run   = 0;
        rd_ops     = 0;
        errors     = 0;
        n_pass     = 0;
        n_fail     = 0;
        for (int i = 0; i < mem_words; i++) begin
            resp_mem[i]  = initial_word(i);
            model_mem[i] = initial_word(i);
        end
        repeat (4) @(posedge CLK);
        #1;
        nRST = 1'b1;

        start = total_errs();
        base  = rd_ops;
        access(0, 32'h40, '0);
        if (rd_ops - base != 2) begin
            $display("read miss made %0d memory reads instead of 2", rd_ops - base);
            errors++;
        end
        base = rd_ops;
        access(0, 32'h44, '0);   // same block, other word
        if (rd_ops != base) begin
            $display("second read of a filled block went to memory");
            errors++;
        end
        report("read miss then hit", start);

        start = total_errs();
        d     = $random(seed);
        access(1, 32'h88, d);
        access(0, 32'h88, '0);
        report("write then read", start);

        // three tags in set 5 with the dirty one as lru victim
        start = total_errs();
        d     = $random(seed);
        access(1, 32'h28, d);
        access(0, 32'h68, '0);
        wr_log.delete();
        access(0, 32'ha8, '0);
        if (wr_log.size() != 2) begin
            $display("dirty victim gave %0d memory writes instead of 2", wr_log.size());
            errors++;
        end else if (wr_log[0] != 32'h28 || wr_log[1] != 32'h2c) begin
            $display("FAILED daddr: got %h %h expected %h %h",
                     wr_log[0], wr_log[1], 32'h28, 32'h2c);
            errors++;
        end
        report("dirty eviction", start);

        start = total_errs();
        access(2, 32'hc0, '0);
        access(3, 32'hc0, $random(seed));   // linked so it passes
        access(0, 32'hc0, '0);
        access(3, 32'hc0, $random(seed));   // link used up
        access(0, 32'hc0, '0);
        access(2, 32'hc0, '0);
        access(1, 32'hc0, $random(seed));
        access(3, 32'hc0, $random(seed));   // broken by the write
        access(0, 32'hc0, '0);
        report("load linked and store conditional", start);

        start = total_errs();
        for (int n = 0; n < n_rand; n++) begin
            kind = int'($random(seed) & 3);
            a    = $random(seed) & 32'h0000_00fc;
            d    = $random(seed);
            if (kind == 3 && link_valid && ($random(seed) & 1) != 0) begin
                a = link_addr;
            end
            access(kind, a, d);
        end
        report("random requests", start);

        start  = total_errs();
        halt   = 1'b1;
        cycles = 0;
        while (!flushed && cycles < flush_cycles) begin
            @(posedge CLK);
            #1;
            cycles++;
        end
        if (!flushed) begin
            $display("flushed did not rise within %0d cycles of halt", flush_cycles);
            errors++;
        end else begin
            for (int i = 0; i < mem_words; i++) begin
                if (resp_mem[i] != model_mem[i]) begin
                    $display("FAILED memory word %h: got %h expected %h",
                             i * 4, resp_mem[i], model_mem[i]);
                    errors++;
                end
            end
            repeat (4) begin
                @(posedge CLK);
                #1;
                if (!flushed) begin
                    $display("flushed fell after it had risen");
                    errors++;
                end
            end
        end
        report("halt flush", start);

        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 n_pass + n_fail, n_pass, n_fail, total_errs());
        if (total_errs() == 0 && n_fail == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/tb_dcache_assertions.sv
`default_nettype none

module tb_dcache_assertions (
    input logic              CLK,
    input logic              nRST,
    input logic              dREN,
    input logic              dWEN,
    input dcache_pkg::word_t daddr,
    input dcache_pkg::word_t dstore,
    input logic              dwait,
    input logic              flushed
);

    int fails = 0;

    mem_excl: assert property (@(posedge CLK) disable iff (!nRST) !(dREN && dWEN))
        else begin
            $error("dREN and dWEN high together");
            fails++;
        end

    // a waiting word keeps its address and data
    mem_hold: assert property (@(posedge CLK) disable iff (!nRST)
        (dREN || dWEN) && dwait |=> $stable(daddr) && $stable(dstore)
                                     && $stable(dREN) && $stable(dWEN))
        else begin
            $error("memory request changed while dwait was high");
            fails++;
        end

    flushed_hold: assert property (@(posedge CLK) disable iff (!nRST) flushed |=> flushed)
        else begin
            $error("flushed fell after it had risen");
            fails++;
        end

endmodule

bind dcache tb_dcache_assertions u_assertions (
    .CLK     (CLK),
    .nRST    (nRST),
    .dREN    (dREN),
    .dWEN    (dWEN),
    .daddr   (daddr),
    .dstore  (dstore),
    .dwait   (dwait),
    .flushed (flushed)
);

`default_nettype wire
